// File: project.f
+incdir+.
merge_cfg_pkg.sv
merge_req_pkg.sv
index_fifo_if.sv
merge_gen_csr.sv
index_sequencer.sv
index_fifo.sv
request_formatter.sv
merge_data_generator.sv
tb_merge_data_generator.sv

// File: Makefile
# Verilator build and run for the merge-data request generator

VERILATOR ?= verilator
TOP       ?= tb_merge_data_generator
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST OK

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) merge_gen_defines.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_merge_data_generator.sv
/* Testbench for the merge-data request generator: APB tasks, reference model,
   LFSR back-pressure, request checker and watchdog */

`timescale 1ns/1ps
`include "merge_gen_defines.svh"

module tb_merge_data_generator;

    localparam int TOTAL_ITEMS     = 12 + 40;
    localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 8 + 1000;

    logic                      ap_clk = 1'b0;
    logic                      areset_generator;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`MG_APB_ADDR_W-1:0] paddr;
    logic [31:0]               pwdata;
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      req_valid;
    logic                      req_ready = 1'b0;
    logic [`MG_ADDR_W-1:0]     req_addr;
    logic [`MG_INDEX_W-1:0]    req_data;
    logic                      done;

    // Expected configuration of the current run
    logic [15:0] ref_start;
    logic [15:0] ref_stride;
    logic        ref_decr;
    logic [31:0] ref_base;
    logic        ref_left;
    logic [4:0]  ref_amt;

    logic        random_ready = 1'b0;
    logic [15:0] lfsr_state = 16'd71;
    logic [15:0] lfsr_next;

    int          req_count = 0;
    int          run_base = 0;
    logic        stalled = 1'b0;
    logic [31:0] held_addr;
    logic [15:0] held_data;
    merge_req_pkg::mem_request_t exp_req;

    merge_data_generator uut (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req_addr         (req_addr),
        .req_data         (req_data),
        .done             (done)
    );

    always #5 ap_clk = ~ap_clk;

    // ------------------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------------------

    // Galois LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Request for item k of the current run
    function automatic merge_req_pkg::mem_request_t expected_request(input int k);
        merge_req_pkg::mem_request_t r;
        logic [15:0]                 step;
        logic [31:0]                 offset;
        step   = 16'(k * ref_stride);
        r.data = ref_decr ? ref_start - step : ref_start + step;
        offset = ref_left ? ({16'b0, r.data} << ref_amt) : ({16'b0, r.data} >> ref_amt);
        r.addr = ref_base + offset;
        return r;
    endfunction

    // Start in bit 0, op in bit 1, shift direction in bit 2, amount in bits 12 to 8
    function automatic logic [31:0] ctrl_word(input logic go, input logic decr,
                                              input logic left, input logic [4:0] amt);
        return {19'b0, amt, 5'b0, left, decr, go};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge ap_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge ap_clk);
        penable <= 1'b1;
        @(negedge ap_clk);
        check_equal("pready", 32'(pready), 32'd1);
        check_equal("pslverr", 32'(pslverr), 32'd0);
        @(posedge ap_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge ap_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge ap_clk);
        penable <= 1'b1;
        @(negedge ap_clk);
        check_equal("pready", 32'(pready), 32'd1);
        data = prdata;
        err  = pslverr;
        @(posedge ap_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic start_run(input logic [15:0] first, input logic [15:0] stride,
                             input logic [15:0] length, input logic [31:0] base,
                             input logic decr, input logic left, input logic [4:0] amt);
        ref_start  <= first;
        ref_stride <= stride;
        ref_decr   <= decr;
        ref_base   <= base;
        ref_left   <= left;
        ref_amt    <= amt;
        run_base   <= req_count;
        apb_write(merge_cfg_pkg::REG_INDEX_START, 32'(first));
        apb_write(merge_cfg_pkg::REG_STRIDE, 32'(stride));
        apb_write(merge_cfg_pkg::REG_LENGTH, 32'(length));
        apb_write(merge_cfg_pkg::REG_BASE, base);
        apb_write(merge_cfg_pkg::REG_CTRL, ctrl_word(1'b1, decr, left, amt));
    endtask

    task automatic wait_for_done();
        @(negedge ap_clk);
        while (!done)
            @(negedge ap_clk);
    endtask

    // ------------------------------------------------------------------------
    // Back-pressure, checker and watchdog
    // ------------------------------------------------------------------------
    assign lfsr_next = lfsr_step(lfsr_state);

    always @(posedge ap_clk) begin
        if (random_ready) begin
            lfsr_state <= lfsr_next;
            req_ready  <= lfsr_next[0];
        end else begin
            req_ready <= 1'b1;
        end
    end

    always @(negedge ap_clk) begin
        if (areset_generator) begin
            stalled <= 1'b0;
        end else begin
            // A stalled request keeps its payload
            if (stalled) begin
                check_equal("req_valid", 32'(req_valid), 32'd1);
                check_equal("req_addr", req_addr, held_addr);
                check_equal("req_data", 32'(req_data), 32'(held_data));
            end
            if (req_valid && req_ready) begin
                exp_req = expected_request(req_count - run_base);
                check_equal("req_addr", req_addr, exp_req.addr);
                check_equal("req_data", 32'(req_data), 32'(exp_req.data));
                req_count <= req_count + 1;
            end
            stalled   <= req_valid && !req_ready;
            held_addr <= req_addr;
            held_data <= req_data;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Watchdog expired after %0d cycles, the DUT did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "Simulation timeout");
    end

    initial begin
        logic [31:0] rd_data;
        logic        rd_err;
        $timeformat(-9, 0, " ns", 0);
        areset_generator = 1'b1;
        psel             = 1'b0;
        penable          = 1'b0;
        pwrite           = 1'b0;
        paddr            = '0;
        pwdata           = '0;
        repeat (4) @(posedge ap_clk);
        areset_generator <= 1'b0;

        // Idle after reset
        @(negedge ap_clk);
        check_equal("req_valid", 32'(req_valid), 32'd0);
        check_equal("done", 32'(done), 32'd0);
        apb_read(merge_cfg_pkg::REG_STATUS, rd_data, rd_err);
        check_equal("STATUS", rd_data, 32'h0);
        check_equal("pslverr", 32'(rd_err), 32'd0);

        // Increment run with left shift, ready held high
        start_run(16'd5, 16'd3, 16'd12, 32'h0000_1000, 1'b0, 1'b1, 5'd2);
        wait_for_done();
        check_equal("request count", 32'(req_count - run_base), 32'd12);
        apb_read(merge_cfg_pkg::REG_STATUS, rd_data, rd_err);
        check_equal("STATUS", rd_data, 32'h2);

        // Decrement run with right shift, deeper than the FIFO, random ready
        random_ready <= 1'b1;
        start_run(16'd50, 16'd7, 16'd40, 32'h8000_0000, 1'b1, 1'b0, 5'd3);
        apb_write(merge_cfg_pkg::REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b1, 5'd1));
        apb_read(merge_cfg_pkg::REG_STATUS, rd_data, rd_err);
        check_equal("STATUS", rd_data, 32'h1);
        wait_for_done();
        check_equal("request count", 32'(req_count - run_base), 32'd40);
        check_equal("done", 32'(done), 32'd1);
        apb_read(merge_cfg_pkg::REG_STATUS, rd_data, rd_err);
        check_equal("STATUS", rd_data, 32'h2);
        random_ready <= 1'b0;

        // Unmapped address, then a refused zero-length start
        apb_read(8'h3C, rd_data, rd_err);
        check_equal("pslverr", 32'(rd_err), 32'd1);
        run_base <= req_count;
        apb_write(merge_cfg_pkg::REG_LENGTH, 32'd0);
        apb_write(merge_cfg_pkg::REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0, 5'd0));
        apb_read(merge_cfg_pkg::REG_STATUS, rd_data, rd_err);
        check_equal("STATUS", rd_data, 32'h2);
        repeat (50) begin
            @(negedge ap_clk);
            check_equal("req_valid", 32'(req_valid), 32'd0);
        end
        check_equal("request count", 32'(req_count - run_base), 32'd0);

        $display("TEST OK");
        $finish;
    end

endmodule

// File: merge_data_generator.sv
/* Top level of the merge-data request generator */

`timescale 1ns/1ps
`include "merge_gen_defines.svh"

module merge_data_generator (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    // APB slave
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`MG_APB_ADDR_W-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    // Request port
    output logic                      req_valid,
    input  logic                      req_ready,
    output logic [`MG_ADDR_W-1:0]     req_addr,
    output logic [`MG_INDEX_W-1:0]    req_data,
    output logic                      done
);

    merge_cfg_pkg::gen_cfg_t cfg;
    logic                    start;
    logic                    run_done;

    index_fifo_if idx_if ();

    merge_gen_csr u_csr (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .run_done         (run_done),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .cfg              (cfg),
        .start            (start),
        .done             (done)
    );

    index_sequencer u_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg              (cfg),
        .start            (start),
        .fifo             (idx_if.producer)
    );

    index_fifo u_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .fifo             (idx_if.buffer)
    );

    request_formatter u_formatter (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg              (cfg),
        .req_ready        (req_ready),
        .fifo             (idx_if.consumer),
        .req_valid        (req_valid),
        .req_addr         (req_addr),
        .req_data         (req_data),
        .run_done         (run_done)
    );

endmodule

// File: request_formatter.sv
/* Request formatter: pops indices, shifts into addresses, valid/ready output register */

`timescale 1ns/1ps
`include "merge_gen_defines.svh"

module request_formatter (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  merge_cfg_pkg::gen_cfg_t cfg,
    input  logic                    req_ready,
    index_fifo_if.consumer          fifo,
    output logic                    req_valid,
    output logic [`MG_ADDR_W-1:0]   req_addr,
    output merge_req_pkg::index_t   req_data,
    output logic                    run_done
);

    merge_req_pkg::mem_request_t req_q;
    logic                        last_q;
    logic [`MG_ADDR_W-1:0]       index_ext;
    logic [`MG_ADDR_W-1:0]       offset;

    // Refill when the output slot is free or draining this cycle
    assign fifo.pop = ~fifo.empty & (~req_valid | req_ready);

    assign index_ext = `MG_ADDR_W'(fifo.pop_entry.index);
    assign offset    = (cfg.shift_dir == merge_cfg_pkg::SHIFT_LEFT) ?
                       (index_ext << cfg.shift_amt) : (index_ext >> cfg.shift_amt);

    assign req_addr = req_q.addr;
    assign req_data = req_q.data;

    always_ff @(posedge ap_clk) begin
        if (fifo.pop) begin
            req_q.addr <= cfg.base + offset;
            req_q.data <= fifo.pop_entry.index;
            last_q     <= fifo.pop_entry.last;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            req_valid <= 1'b0;
            run_done  <= 1'b0;
        end else begin
            if (fifo.pop)
                req_valid <= 1'b1;
            else if (req_ready)
                req_valid <= 1'b0;
            run_done <= req_valid & req_ready & last_q;
        end
    end

    a_stable_when_stalled: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        req_valid && !req_ready |=> req_valid && $stable(req_addr) && $stable(req_data)
    );

endmodule

// File: index_fifo.sv
/* Synchronous first-word-fall-through index FIFO with programmable-full */

`timescale 1ns/1ps
`include "merge_gen_defines.svh"

module index_fifo (
    input  logic         ap_clk,
    input  logic         areset_generator,
    index_fifo_if.buffer fifo
);

    localparam int PTR_W = $clog2(`MG_FIFO_DEPTH);

    merge_req_pkg::fifo_entry_t mem [`MG_FIFO_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [PTR_W:0]             count;

    assign fifo.pop_entry = mem[rd_ptr];
    assign fifo.empty     = (count == '0);
    assign fifo.full      = (count == (PTR_W+1)'(`MG_FIFO_DEPTH));
    assign fifo.prog_full = (count >= (PTR_W+1)'(`MG_PROG_THRESH));

    always_ff @(posedge ap_clk) begin
        if (fifo.push)
            mem[wr_ptr] <= fifo.push_entry;
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (fifo.push)
                wr_ptr <= wr_ptr + 1'b1;
            if (fifo.pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(fifo.push) - (PTR_W+1)'(fifo.pop);
        end
    end

    a_no_overflow: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        fifo.push && fifo.full |-> fifo.pop
    );

    a_no_underflow: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        fifo.pop |-> !fifo.empty
    );

endmodule

// File: index_sequencer.sv
/* Index sequencer FSM with stride counter and programmable-full pause */

`timescale 1ns/1ps
`include "merge_gen_defines.svh"

module index_sequencer (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  merge_cfg_pkg::gen_cfg_t cfg,
    input  logic                    start,
    index_fifo_if.producer          fifo
);

    merge_req_pkg::seq_state_e state;
    merge_req_pkg::index_t     count;
    logic [`MG_INDEX_W-1:0]    remaining;
    logic                      last_push;

    // One index per cycle while busy, last flagged on the final item
    assign fifo.push             = (state == merge_req_pkg::SEQ_BUSY);
    assign last_push             = (remaining == `MG_INDEX_W'(1));
    assign fifo.push_entry.index = count;
    assign fifo.push_entry.last  = last_push;

    // -------------------------------------------------------------------------
    // State machine
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= merge_req_pkg::SEQ_IDLE;
        end else begin
            case (state)
                merge_req_pkg::SEQ_IDLE: begin
                    if (start)
                        state <= merge_req_pkg::SEQ_BUSY;
                end
                merge_req_pkg::SEQ_BUSY: begin
                    if (last_push)
                        state <= merge_req_pkg::SEQ_DONE;
                    else if (fifo.prog_full)
                        state <= merge_req_pkg::SEQ_PAUSE;
                end
                merge_req_pkg::SEQ_PAUSE: begin
                    if (!fifo.prog_full)
                        state <= merge_req_pkg::SEQ_BUSY;
                end
                default: state <= merge_req_pkg::SEQ_IDLE;
            endcase
        end
    end

    // Stride counter wraps modulo 2^16
    always_ff @(posedge ap_clk) begin
        if (state == merge_req_pkg::SEQ_IDLE && start) begin
            count     <= cfg.index_start;
            remaining <= cfg.length;
        end else if (fifo.push) begin
            if (cfg.op == merge_cfg_pkg::STEP_INCR)
                count <= count + cfg.stride;
            else
                count <= count - cfg.stride;
            remaining <= remaining - `MG_INDEX_W'(1);
        end
    end

    a_no_push_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        fifo.push |-> !fifo.full
    );

endmodule

// File: merge_gen_csr.sv
/* APB register block: configuration registers, start gating, busy and done status */

`timescale 1ns/1ps
`include "merge_gen_defines.svh"

module merge_gen_csr (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`MG_APB_ADDR_W-1:0] paddr,
    input  logic [31:0]               pwdata,
    input  logic                      run_done,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output merge_cfg_pkg::gen_cfg_t   cfg,
    output logic                      start,
    output logic                      done
);

    logic busy;
    logic addr_hit;
    logic wr_en;
    logic cfg_wr;
    logic start_accept;

    // -------------------------------------------------------------------------
    // APB access decode
    // -------------------------------------------------------------------------
    assign pready  = 1'b1;
    assign wr_en   = psel & penable & pwrite;
    assign pslverr = psel & penable & ~addr_hit;

    // Configuration is frozen for the duration of a run
    assign cfg_wr = wr_en & ~busy;

    assign start_accept = wr_en & (paddr == merge_cfg_pkg::REG_CTRL) & pwdata[0]
                        & ~busy & (cfg.length != '0);

    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            merge_cfg_pkg::REG_CTRL:
                prdata = {19'b0, cfg.shift_amt, 5'b0, cfg.shift_dir, cfg.op, 1'b0};
            merge_cfg_pkg::REG_STATUS:
                prdata = {30'b0, done, busy};
            merge_cfg_pkg::REG_INDEX_START:
                prdata = {16'b0, cfg.index_start};
            merge_cfg_pkg::REG_STRIDE:
                prdata = {16'b0, cfg.stride};
            merge_cfg_pkg::REG_LENGTH:
                prdata = {16'b0, cfg.length};
            merge_cfg_pkg::REG_BASE:
                prdata = cfg.base;
            default:
                addr_hit = 1'b0;
        endcase
    end

    // -------------------------------------------------------------------------
    // Configuration registers
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            cfg <= '0;
        end else if (cfg_wr) begin
            case (paddr)
                merge_cfg_pkg::REG_CTRL: begin
                    cfg.op        <= merge_cfg_pkg::step_op_e'(pwdata[1]);
                    cfg.shift_dir <= merge_cfg_pkg::shift_dir_e'(pwdata[2]);
                    cfg.shift_amt <= pwdata[12:8];
                end
                merge_cfg_pkg::REG_INDEX_START: cfg.index_start <= pwdata[15:0];
                merge_cfg_pkg::REG_STRIDE:      cfg.stride      <= pwdata[15:0];
                merge_cfg_pkg::REG_LENGTH:      cfg.length      <= pwdata[15:0];
                merge_cfg_pkg::REG_BASE:        cfg.base        <= pwdata;
                default: ;
            endcase
        end
    end

    // Run control, done stays up until the next accepted start
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            start <= start_accept;
            if (start_accept) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (run_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // Completion only arrives for a run in flight
    a_run_done_while_busy: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        run_done |-> busy
    );

endmodule

// File: index_fifo_if.sv
/* Index buffer link with producer, buffer and consumer views */

`timescale 1ns/1ps

interface index_fifo_if;

    // Push side
    logic                        push;
    merge_req_pkg::fifo_entry_t  push_entry;
    logic                        prog_full;
    logic                        full;

    // Pop side, first-word-fall-through
    logic                        pop;
    merge_req_pkg::fifo_entry_t  pop_entry;
    logic                        empty;

    modport producer (output push, output push_entry, input prog_full, input full);
    modport buffer   (input push, input push_entry, output prog_full, output full,
                      input pop, output pop_entry, output empty);
    modport consumer (output pop, input pop_entry, input empty);

endinterface

// File: merge_req_pkg.sv
/* Data-path types: index, buffer entry, sequencer state, memory request */

`include "merge_gen_defines.svh"

package merge_req_pkg;

    typedef logic [`MG_INDEX_W-1:0] index_t;

    // Last flag rides along with the index through the buffer
    typedef struct packed {
        logic   last;
        index_t index;
    } fifo_entry_t;

    typedef enum logic [2:0] {SEQ_IDLE, SEQ_BUSY, SEQ_PAUSE, SEQ_DONE} seq_state_e;

    typedef struct packed {
        logic [`MG_ADDR_W-1:0] addr;
        index_t                data;
    } mem_request_t;

endpackage

// File: merge_cfg_pkg.sv
/* Programming-side types: register map, step opcode, shift direction, config struct */

`include "merge_gen_defines.svh"

package merge_cfg_pkg;

    // Word-aligned register map
    typedef enum logic [`MG_APB_ADDR_W-1:0] {
        REG_CTRL        = 8'h00,
        REG_STATUS      = 8'h04,
        REG_INDEX_START = 8'h08,
        REG_STRIDE      = 8'h0C,
        REG_LENGTH      = 8'h10,
        REG_BASE        = 8'h14
    } reg_addr_e;

    typedef enum logic {STEP_INCR = 1'b0, STEP_DECR = 1'b1} step_op_e;

    typedef enum logic {SHIFT_RIGHT = 1'b0, SHIFT_LEFT = 1'b1} shift_dir_e;

    typedef struct packed {
        logic [`MG_INDEX_W-1:0] index_start;
        logic [`MG_INDEX_W-1:0] stride;
        logic [`MG_INDEX_W-1:0] length;
        logic [`MG_ADDR_W-1:0]  base;
        step_op_e               op;
        shift_dir_e             shift_dir;
        logic [4:0]             shift_amt;
    } gen_cfg_t;

endpackage

// File: merge_gen_defines.svh
/* Width, depth and threshold macros for the merge-data request generator */

`ifndef MERGE_GEN_DEFINES_SVH
`define MERGE_GEN_DEFINES_SVH

// Data path widths
`define MG_INDEX_W      16
`define MG_ADDR_W       32

// Index buffer sizing, programmable-full leaves headroom above threshold
`define MG_FIFO_DEPTH   16
`define MG_PROG_THRESH  8

// APB register space
`define MG_APB_ADDR_W   8

`endif
